// ==== ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    // data path width
    localparam int XLEN = 32;

    // highest register number, sets the register address width
    localparam int LINK_REG = 31;
    localparam int REG_ADDR_W = $clog2(LINK_REG + 1);

    localparam int SHAMT_W = 5;
    localparam int IMM_W = 16;

    // leading zero/one count needs one more bit to hold XLEN itself
    localparam int CNT_W = $clog2(XLEN) + 1;

    // opcodes handled by the execute stage
    typedef enum logic [7:0] {
        OP_NOP,
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_ADDI,
        OP_ADDIU,
        OP_SLT,
        OP_SLTU,
        OP_SLTI,
        OP_SLTIU,
        OP_AND,
        OP_ANDI,
        OP_OR,
        OP_ORI,
        OP_XOR,
        OP_XORI,
        OP_NOR,
        OP_LUI,
        OP_SLL,
        OP_SLLV,
        OP_SRL,
        OP_SRLV,
        OP_SRA,
        OP_SRAV,
        OP_CLZ,
        OP_CLO,
        OP_MOVZ,
        OP_MOVN,
        OP_MUL,
        OP_MULT,
        OP_MULTU,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO
    } ex_op_e;

    // decoded instruction from the decode stage
    typedef struct packed {
        ex_op_e                op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       rs_val;
        logic [XLEN-1:0]       rt_val;
        logic [IMM_W-1:0]      imm;
        logic [SHAMT_W-1:0]    shamt;
    } ex_req_t;

    // issue register contents, operands already selected
    typedef struct packed {
        logic                  valid;
        ex_op_e                op;
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;
        logic [SHAMT_W-1:0]    shamt;
        logic [REG_ADDR_W-1:0] dest;
    } ex_issue_t;

    // register file write
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] dest;
        logic [XLEN-1:0]       value;
        logic                  overflow;
    } ex_wb_t;

endpackage

`default_nettype wire

// ==== ex_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_issue (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush_i,
    input  logic               issue_i,
    input  ex_pkg::ex_req_t    req_i,
    output ex_pkg::ex_issue_t  issue_o
);

    import ex_pkg::*;

    logic [XLEN-1:0] imm_sext;
    logic [XLEN-1:0] imm_zext;
    logic [XLEN-1:0] imm_upper;
    ex_issue_t       issue_d;

    assign imm_sext = {{(XLEN - IMM_W){req_i.imm[IMM_W-1]}}, req_i.imm};
    assign imm_zext = {{(XLEN - IMM_W){1'b0}}, req_i.imm};
    assign imm_upper = {req_i.imm, {(XLEN - IMM_W){1'b0}}};

    always_comb
    begin
        issue_d.valid = issue_i & ~flush_i;
        issue_d.op = req_i.op;
        issue_d.a = req_i.rs_val;
        issue_d.b = req_i.rt_val;
        issue_d.shamt = req_i.shamt;
        issue_d.dest = req_i.rd;
        case (req_i.op)
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU:
            begin
                issue_d.b = imm_sext;
                issue_d.dest = req_i.rt;
            end
            OP_ANDI, OP_ORI, OP_XORI:
            begin
                issue_d.b = imm_zext;
                issue_d.dest = req_i.rt;
            end
            OP_LUI:
            begin
                issue_d.b = imm_upper;
                issue_d.dest = req_i.rt;
            end
            // shifts work on rt
            OP_SLL, OP_SRL, OP_SRA:
            begin
                issue_d.a = req_i.rt_val;
            end
            OP_SLLV, OP_SRLV, OP_SRAV:
            begin
                issue_d.a = req_i.rt_val;
                issue_d.shamt = req_i.rs_val[SHAMT_W-1:0];
            end
            // no register result
            OP_NOP, OP_MULT, OP_MULTU, OP_MTHI, OP_MTLO:
            begin
                issue_d.dest = '0;
            end
            default:
            begin
                issue_d.dest = req_i.rd;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (issue_i)
        begin
            issue_o <= issue_d;
        end
        // valid bit overrides the payload load above
        if (!rst_n)
        begin
            issue_o.valid <= 1'b0;
        end
        else
        begin
            issue_o.valid <= issue_d.valid;
        end
    end

endmodule

`default_nettype wire

// ==== ex_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush_i,
    input  ex_pkg::ex_issue_t       issue_i,
    output ex_pkg::ex_wb_t          wb_o,
    output logic [ex_pkg::XLEN-1:0] hi_o,
    output logic [ex_pkg::XLEN-1:0] lo_o
);

    import ex_pkg::*;

    logic [XLEN-1:0]          a;
    logic [XLEN-1:0]          b;
    logic                     is_sub;
    logic [XLEN-1:0]          b_inv;
    logic [XLEN:0]            sum_full;
    logic [XLEN-1:0]          sum;
    logic                     sum_ovf;
    logic                     lt_s;
    logic                     lt_u;
    logic [XLEN-1:0]          clz_src;
    logic [CNT_W-1:0]         lead_cnt;
    logic signed [2*XLEN-1:0] prod_s;
    logic [2*XLEN-1:0]        prod_u;
    logic [XLEN-1:0]          hi_q;
    logic [XLEN-1:0]          lo_q;
    logic [XLEN-1:0]          result;
    logic                     write_en;
    logic                     trap;

    assign a = issue_i.a;
    assign b = issue_i.b;

    // subtract and compares share the adder
    always_comb
    begin
        case (issue_i.op)
            OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_SLTI, OP_SLTIU: is_sub = 1'b1;
            default: is_sub = 1'b0;
        endcase
    end

    assign b_inv = is_sub ? ~b : b;
    assign sum_full = {1'b0, a} + {1'b0, b_inv} + {{XLEN{1'b0}}, is_sub};
    assign sum = sum_full[XLEN-1:0];
    assign sum_ovf = (a[XLEN-1] == b_inv[XLEN-1]) && (sum[XLEN-1] != a[XLEN-1]);

    // a is less when negative if signs differ, else sign of a - b
    assign lt_s = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : sum[XLEN-1];
    // no carry out of a + ~b + 1 means borrow
    assign lt_u = ~sum_full[XLEN];

    // clo counts zeros of the inverted word
    assign clz_src = (issue_i.op == OP_CLO) ? ~a : a;

    always_comb
    begin
        lead_cnt = CNT_W'(XLEN);
        for (int i = 0; i < XLEN; i++)
        begin
            if (clz_src[i])
            begin
                lead_cnt = CNT_W'(XLEN - 1 - i);
            end
        end
    end

    assign prod_s = (2*XLEN)'($signed(a)) * (2*XLEN)'($signed(b));
    assign prod_u = (2*XLEN)'(a) * (2*XLEN)'(b);

    always_comb
    begin
        result = '0;
        write_en = 1'b1;
        trap = 1'b0;
        case (issue_i.op)
            OP_ADD, OP_SUB, OP_ADDI:
            begin
                result = sum;
                trap = 1'b1;
            end
            OP_ADDU, OP_SUBU, OP_ADDIU: result = sum;
            OP_SLT, OP_SLTI: result = XLEN'(lt_s);
            OP_SLTU, OP_SLTIU: result = XLEN'(lt_u);
            OP_AND, OP_ANDI: result = a & b;
            OP_OR, OP_ORI: result = a | b;
            OP_XOR, OP_XORI: result = a ^ b;
            OP_NOR: result = ~(a | b);
            OP_LUI: result = b;
            OP_SLL, OP_SLLV: result = a << issue_i.shamt;
            OP_SRL, OP_SRLV: result = a >> issue_i.shamt;
            OP_SRA, OP_SRAV: result = $unsigned($signed(a) >>> issue_i.shamt);
            OP_CLZ, OP_CLO: result = XLEN'(lead_cnt);
            OP_MOVZ:
            begin
                result = a;
                write_en = (b == '0);
            end
            OP_MOVN:
            begin
                result = a;
                write_en = (b != '0);
            end
            OP_MUL: result = prod_s[XLEN-1:0];
            OP_MFHI: result = hi_q;
            OP_MFLO: result = lo_q;
            default: result = '0;
        endcase
    end

    // hi/lo written at the end of the issue cycle
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            hi_q <= '0;
            lo_q <= '0;
        end
        else if (issue_i.valid && !flush_i)
        begin
            case (issue_i.op)
                OP_MULT: {hi_q, lo_q} <= prod_s;
                OP_MULTU: {hi_q, lo_q} <= prod_u;
                OP_MTHI: hi_q <= a;
                OP_MTLO: lo_q <= a;
                default: ;
            endcase
        end
    end

    assign hi_o = hi_q;
    assign lo_o = lo_q;

    assign wb_o.valid = issue_i.valid & write_en;
    assign wb_o.dest = issue_i.dest;
    assign wb_o.value = result;
    assign wb_o.overflow = issue_i.valid & trap & sum_ovf;

endmodule

`default_nettype wire

// ==== ex_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_writeback (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush_i,
    input  ex_pkg::ex_wb_t  res_i,
    output ex_pkg::ex_wb_t  wb_o
);

    // control bits
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wb_o.valid <= 1'b0;
            wb_o.overflow <= 1'b0;
        end
        else
        begin
            wb_o.valid <= res_i.valid & ~flush_i;
            wb_o.overflow <= res_i.overflow & ~flush_i;
        end
    end

    // trapped result writes nothing useful
    // dest zero is dropped by the register file anyway
    always_ff @(posedge clk)
    begin
        if (res_i.overflow)
        begin
            wb_o.value <= '0;
            wb_o.dest <= '0;
        end
        else
        begin
            wb_o.value <= res_i.value;
            wb_o.dest <= res_i.dest;
        end
    end

endmodule

`default_nettype wire

// ==== ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush_i,
    input  logic                    issue_i,
    input  ex_pkg::ex_req_t         req_i,
    output ex_pkg::ex_wb_t          wb_o,
    output logic [ex_pkg::XLEN-1:0] hi_o,
    output logic [ex_pkg::XLEN-1:0] lo_o
);

    import ex_pkg::*;

    ex_issue_t issue;
    ex_wb_t    alu_res;

    ex_issue u_issue (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush_i (flush_i),
        .issue_i (issue_i),
        .req_i   (req_i),
        .issue_o (issue)
    );

    // result is combinational, hi/lo registered inside
    ex_alu u_alu (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush_i (flush_i),
        .issue_i (issue),
        .wb_o    (alu_res),
        .hi_o    (hi_o),
        .lo_o    (lo_o)
    );

    ex_writeback u_writeback (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush_i (flush_i),
        .res_i   (alu_res),
        .wb_o    (wb_o)
    );

endmodule

`default_nettype wire

// ==== ex_stage_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage_assertions (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    flush_i,
    input logic                    issue_i,
    input ex_pkg::ex_req_t         req_i,
    input ex_pkg::ex_wb_t          wb_i,
    input logic [ex_pkg::XLEN-1:0] hi_i,
    input logic [ex_pkg::XLEN-1:0] lo_i
);

    import ex_pkg::*;

    logic              req_valid;
    ex_req_t           req_q;
    ex_wb_t            ref_res;
    ex_wb_t            exp_wb;
    logic [XLEN-1:0]   exp_hi;
    logic [XLEN-1:0]   exp_lo;
    logic [2*XLEN-1:0] ref_prod_s;
    logic [2*XLEN-1:0] ref_prod_u;
    int                err_valid = 0;
    int                err_ovf = 0;
    int                err_value = 0;
    int                err_dest = 0;
    int                err_hilo = 0;
    int                fail_cnt;

    // expected writeback word for one request, given the current hi/lo
    function automatic ex_wb_t ref_wb(input ex_req_t r, input logic [XLEN-1:0] hi,
                                      input logic [XLEN-1:0] lo);
        logic [XLEN-1:0]   s;
        logic [XLEN-1:0]   t;
        logic [XLEN-1:0]   se;
        logic [2*XLEN-1:0] wide;
        int                cnt;
        logic              stop;
        ex_wb_t            w;
        s = r.rs_val;
        t = r.rt_val;
        se = {{(XLEN - IMM_W){r.imm[IMM_W-1]}}, r.imm};
        wide = '0;
        cnt = 0;
        stop = 1'b0;
        w.valid = 1'b1;
        w.overflow = 1'b0;
        w.value = '0;
        case (r.op)
            OP_ADD, OP_ADDU: wide = {{XLEN{s[XLEN-1]}}, s} + {{XLEN{t[XLEN-1]}}, t};
            OP_SUB, OP_SUBU: wide = {{XLEN{s[XLEN-1]}}, s} - {{XLEN{t[XLEN-1]}}, t};
            OP_ADDI, OP_ADDIU: wide = {{XLEN{s[XLEN-1]}}, s} + {{XLEN{se[XLEN-1]}}, se};
            OP_SLT: w.value = XLEN'($signed(s) < $signed(t));
            OP_SLTI: w.value = XLEN'($signed(s) < $signed(se));
            OP_SLTU: w.value = XLEN'(s < t);
            OP_SLTIU: w.value = XLEN'(s < se);
            OP_AND: w.value = s & t;
            OP_ANDI: w.value = s & XLEN'(r.imm);
            OP_OR: w.value = s | t;
            OP_ORI: w.value = s | XLEN'(r.imm);
            OP_XOR: w.value = s ^ t;
            OP_XORI: w.value = s ^ XLEN'(r.imm);
            OP_NOR: w.value = ~(s | t);
            OP_LUI: w.value = {r.imm, {(XLEN - IMM_W){1'b0}}};
            OP_SLL: w.value = t << r.shamt;
            OP_SLLV: w.value = t << s[SHAMT_W-1:0];
            OP_SRL: w.value = t >> r.shamt;
            OP_SRLV: w.value = t >> s[SHAMT_W-1:0];
            OP_SRA: w.value = $signed(t) >>> r.shamt;
            OP_SRAV: w.value = $signed(t) >>> s[SHAMT_W-1:0];
            OP_CLZ, OP_CLO:
            begin
                for (int i = XLEN - 1; i >= 0; i--)
                begin
                    if (!stop && s[i] == (r.op == OP_CLO))
                        cnt++;
                    else
                        stop = 1'b1;
                end
                w.value = XLEN'(cnt);
            end
            OP_MOVZ:
            begin
                w.value = s;
                w.valid = (t == '0);
            end
            OP_MOVN:
            begin
                w.value = s;
                w.valid = (t != '0);
            end
            // low word is the same for signed and unsigned
            OP_MUL: w.value = s * t;
            OP_MFHI: w.value = hi;
            OP_MFLO: w.value = lo;
            default: w.value = '0;
        endcase
        case (r.op)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_ADDI, OP_ADDIU: w.value = wide[XLEN-1:0];
            default: ;
        endcase
        case (r.op)
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: w.dest = r.rt;
            OP_NOP, OP_MULT, OP_MULTU, OP_MTHI, OP_MTLO: w.dest = '0;
            default: w.dest = r.rd;
        endcase
        // sign of the wide sum disagrees with bit XLEN-1 on signed overflow
        if ((r.op == OP_ADD || r.op == OP_SUB || r.op == OP_ADDI) && wide[XLEN] != wide[XLEN-1])
        begin
            w.overflow = 1'b1;
            w.value = '0;
            w.dest = '0;
        end
        return w;
    endfunction

    assign ref_prod_s = {{XLEN{req_q.rs_val[XLEN-1]}}, req_q.rs_val}
                      * {{XLEN{req_q.rt_val[XLEN-1]}}, req_q.rt_val};
    assign ref_prod_u = {{XLEN{1'b0}}, req_q.rs_val} * {{XLEN{1'b0}}, req_q.rt_val};

    always_comb
    begin
        ref_res = ref_wb(req_q, exp_hi, exp_lo);
    end

    always_ff @(posedge clk)
    begin
        req_q <= req_i;
    end

    // two-edge model of the stage
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            req_valid <= 1'b0;
            exp_wb <= '0;
            exp_hi <= '0;
            exp_lo <= '0;
        end
        else
        begin
            req_valid <= issue_i & ~flush_i;
            exp_wb.valid <= req_valid & ~flush_i & ref_res.valid;
            exp_wb.overflow <= req_valid & ~flush_i & ref_res.overflow;
            exp_wb.value <= ref_res.value;
            exp_wb.dest <= ref_res.dest;
            if (req_valid && !flush_i)
            begin
                case (req_q.op)
                    OP_MULT: {exp_hi, exp_lo} <= ref_prod_s;
                    OP_MULTU: {exp_hi, exp_lo} <= ref_prod_u;
                    OP_MTHI: exp_hi <= req_q.rs_val;
                    OP_MTLO: exp_lo <= req_q.rs_val;
                    default: ;
                endcase
            end
        end
    end

    assign fail_cnt = err_valid + err_ovf + err_value + err_dest + err_hilo;

    a_valid: assert property (@(posedge clk) disable iff (!rst_n) wb_i.valid == exp_wb.valid)
        else
        begin
            $error("** Error wb_o.valid 0x%0h expected 0x%0h", wb_i.valid, exp_wb.valid);
            err_valid++;
        end

    a_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        wb_i.overflow == exp_wb.overflow)
        else
        begin
            $error("** Error wb_o.overflow 0x%0h expected 0x%0h", wb_i.overflow,
                   exp_wb.overflow);
            err_ovf++;
        end

    a_value: assert property (@(posedge clk) disable iff (!rst_n)
        exp_wb.valid |-> wb_i.value == exp_wb.value)
        else
        begin
            $error("** Error wb_o.value 0x%08h expected 0x%08h", wb_i.value, exp_wb.value);
            err_value++;
        end

    a_dest: assert property (@(posedge clk) disable iff (!rst_n)
        exp_wb.valid |-> wb_i.dest == exp_wb.dest)
        else
        begin
            $error("** Error wb_o.dest 0x%02h expected 0x%02h", wb_i.dest, exp_wb.dest);
            err_dest++;
        end

    a_hilo: assert property (@(posedge clk) disable iff (!rst_n)
        hi_i == exp_hi && lo_i == exp_lo)
        else
        begin
            $error("** Error hi_o/lo_o 0x%08h/0x%08h expected 0x%08h/0x%08h",
                   hi_i, lo_i, exp_hi, exp_lo);
            err_hilo++;
        end

endmodule

`default_nettype wire

// ==== tb_ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;

    import ex_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int DRAIN = 4;
    localparam int N_RAND = 150;
    localparam int N_OVF = 8;
    localparam int N_CNT = 16;
    localparam int N_MOV = 10;
    localparam int N_MUL = 6;
    localparam int N_FLUSH = 4;
    localparam int NUM_TESTS = 6;
    // one request per cycle in every test, then drain and margin
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_RAND + (12 + N_OVF)
                                  + 2 * (2 + XLEN + N_CNT) + 4 * N_MOV + 11 * N_MUL
                                  + 6 * N_FLUSH + NUM_TESTS * DRAIN + 100;

    logic            clk;
    logic            rst_n;
    logic            flush;
    logic            issue;
    ex_req_t         req;
    ex_wb_t          wb;
    logic [XLEN-1:0] hi;
    logic [XLEN-1:0] lo;
    logic [31:0]     rng_state;
    int              cycle_cnt = 0;
    int              tests_failed;
    int              fail_mark;

    ex_stage i_ex_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush_i (flush),
        .issue_i (issue),
        .req_i   (req),
        .wb_o    (wb),
        .hi_o    (hi),
        .lo_o    (lo)
    );

    bind ex_stage ex_stage_assertions u_assertions (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush_i (flush_i),
        .issue_i (issue_i),
        .req_i   (req_i),
        .wb_i    (wb_o),
        .hi_i    (hi_o),
        .lo_i    (lo_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("timeout, run exceeded %0d clock cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw(output logic [31:0] v);
        rng_state = xorshift32(rng_state);
        v = rng_state;
    endtask

    // one request per falling edge, register numbers and shamt random
    task automatic issue_req(input ex_op_e op, input logic [XLEN-1:0] rs_val,
                             input logic [XLEN-1:0] rt_val, input logic [IMM_W-1:0] imm);
        logic [31:0] r;
        draw(r);
        @(negedge clk);
        issue = 1'b1;
        flush = 1'b0;
        req.op = op;
        req.rs = r[4:0];
        req.rt = r[9:5];
        req.rd = r[14:10];
        req.shamt = r[19:15];
        req.rs_val = rs_val;
        req.rt_val = rt_val;
        req.imm = imm;
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(negedge clk);
            issue = 1'b0;
            flush = 1'b0;
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        idle(DRAIN);
        errs = i_ex_stage.u_assertions.fail_cnt - fail_mark;
        fail_mark = i_ex_stage.u_assertions.fail_cnt;
        if (errs != 0)
        begin
            tests_failed++;
            $display("test %-14s failed, %0d assertion failures", name, errs);
        end
        else
        begin
            $display("test %-14s ok", name);
        end
    endtask

    task automatic random_alu_ops();
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] t;
        for (int i = 0; i < N_RAND; i++)
        begin
            draw(r);
            draw(s);
            draw(t);
            // OP_ADD through OP_SRAV
            issue_req(ex_op_e'(8'(1 + r % 24)), s, t, r[31:16]);
        end
        end_test("alu random");
    endtask

    task automatic overflow_cases();
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] t;
        issue_req(OP_ADD, 32'h7fff_ffff, 32'h0000_0001, '0);
        issue_req(OP_ADD, 32'h8000_0000, 32'hffff_ffff, '0);
        issue_req(OP_ADD, 32'h7fff_fffe, 32'h0000_0001, '0);
        issue_req(OP_ADD, 32'hffff_ffff, 32'h8000_0001, '0);
        issue_req(OP_SUB, 32'h8000_0000, 32'h0000_0001, '0);
        issue_req(OP_SUB, 32'h7fff_ffff, 32'hffff_ffff, '0);
        issue_req(OP_SUB, 32'hffff_ffff, 32'hffff_ffff, '0);
        issue_req(OP_SUB, 32'h0000_0000, 32'h8000_0000, '0);
        issue_req(OP_ADDI, 32'h7fff_ffff, '0, 16'h0001);
        issue_req(OP_ADDI, 32'h8000_0000, '0, 16'h8000);
        issue_req(OP_ADDI, 32'h7fff_fffe, '0, 16'h0001);
        issue_req(OP_ADDI, 32'h0000_0005, '0, 16'hfffb);
        for (int i = 0; i < N_OVF; i++)
        begin
            draw(r);
            draw(s);
            draw(t);
            if (r[0])
                issue_req(OP_ADD, s, t, '0);
            else if (r[1])
                issue_req(OP_SUB, s, t, '0);
            else
                issue_req(OP_ADDI, s, t, r[31:16]);
        end
        end_test("overflow");
    endtask

    task automatic leading_count_cases();
        logic [31:0] r;
        logic [31:0] s;
        issue_req(OP_CLZ, '0, '0, '0);
        issue_req(OP_CLZ, '1, '0, '0);
        issue_req(OP_CLO, '0, '0, '0);
        issue_req(OP_CLO, '1, '0, '0);
        for (int i = 0; i < XLEN; i++)
        begin
            issue_req(OP_CLZ, 32'h1 << i, '0, '0);
            issue_req(OP_CLO, ~(32'h1 << i), '0, '0);
        end
        for (int i = 0; i < N_CNT; i++)
        begin
            draw(r);
            draw(s);
            issue_req(OP_CLZ, s >> r[4:0], '0, '0);
            issue_req(OP_CLO, ~(s >> r[9:5]), '0, '0);
        end
        end_test("clz/clo");
    endtask

    task automatic cond_move_cases();
        logic [31:0] s;
        logic [31:0] t;
        for (int i = 0; i < N_MOV; i++)
        begin
            draw(s);
            draw(t);
            issue_req(OP_MOVZ, s, '0, '0);
            issue_req(OP_MOVZ, s, t | 32'h1, '0);
            issue_req(OP_MOVN, s, '0, '0);
            issue_req(OP_MOVN, s, t | 32'h1, '0);
        end
        end_test("movz/movn");
    endtask

    task automatic hilo_sequences();
        logic [31:0] s;
        logic [31:0] t;
        for (int i = 0; i < N_MUL; i++)
        begin
            draw(s);
            draw(t);
            if (i == 0)
            begin
                s = 32'h8000_0000;
                t = 32'h8000_0000;
            end
            else if (i == 1)
            begin
                s = 32'hffff_ffff;
                t = 32'h7fff_ffff;
            end
            issue_req(OP_MULT, s, t, '0);
            issue_req(OP_MFHI, '0, '0, '0);
            issue_req(OP_MFLO, '0, '0, '0);
            issue_req(OP_MULTU, s, t, '0);
            issue_req(OP_MFHI, '0, '0, '0);
            issue_req(OP_MFLO, '0, '0, '0);
            issue_req(OP_MTHI, t, '0, '0);
            issue_req(OP_MTLO, s, '0, '0);
            issue_req(OP_MFHI, '0, '0, '0);
            issue_req(OP_MFLO, '0, '0, '0);
            issue_req(OP_MUL, s, t, '0);
        end
        end_test("hi/lo");
    endtask

    task automatic flush_in_flight();
        logic [31:0] s;
        logic [31:0] t;
        for (int i = 0; i < N_FLUSH; i++)
        begin
            draw(s);
            draw(t);
            issue_req(OP_MULT, s, t, '0);
            // mult sits in the alu, add is being issued
            issue_req(OP_ADD, s, t, '0);
            flush = 1'b1;
            issue_req(OP_MFHI, '0, '0, '0);
            issue_req(OP_MFLO, '0, '0, '0);
            issue_req(OP_SUB, t, s, '0);
            @(negedge clk);
            issue = 1'b0;
            flush = 1'b1;
        end
        end_test("flush");
    endtask

    initial
    begin
        rng_state = 32'h48dd0fd2;
        rst_n = 1'b0;
        issue = 1'b0;
        flush = 1'b0;
        req = '0;
        tests_failed = 0;
        fail_mark = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        random_alu_ops();
        overflow_cases();
        leading_count_cases();
        cond_move_cases();
        hilo_sequences();
        flush_in_flight();
        $display("tests run %0d, tests failed %0d, assertion failures %0d", NUM_TESTS,
                 tests_failed, i_ex_stage.u_assertions.fail_cnt);
        if (tests_failed == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
ex_pkg.sv
ex_issue.sv
ex_alu.sv
ex_writeback.sv
ex_stage.sv
ex_stage_assertions.sv
tb_ex_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run with Verilator, then look for the pass message in the log
cd "$(dirname "$0")" &&
rm -f build.log sim.log &&
verilator --binary --timing --assert --top-module tb_ex_stage -f vlog.f \
    -o tb_ex_stage > build.log 2>&1 &&
./obj_dir/tb_ex_stage +verilator+error+limit+10000 > sim.log 2>&1
grep -q '^\*\*\* TEST PASSED \*\*\*$' sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }
